/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // datapath widths
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [3:0]        opcode_t;
    typedef logic [3:0]        alu_func_t;

    // major opcodes in ir[15:12], unlisted codes halt
    localparam opcode_t OP_LOAD  = 4'h0;
    localparam opcode_t OP_STORE = 4'h1;
    localparam opcode_t OP_ALU   = 4'h2;
    localparam opcode_t OP_JUMP  = 4'h3;
    localparam opcode_t OP_JZ    = 4'h4;
    localparam opcode_t OP_HALT  = 4'hf;

    // alu functions in ir[11:8]
    localparam alu_func_t ALU_ADD  = 4'h0;
    localparam alu_func_t ALU_SUB  = 4'h1;
    localparam alu_func_t ALU_MUL  = 4'h2;
    localparam alu_func_t ALU_DIV  = 4'h3;
    localparam alu_func_t ALU_SHL  = 4'h4;
    localparam alu_func_t ALU_SHR  = 4'h5;
    localparam alu_func_t ALU_ROL  = 4'h6;
    localparam alu_func_t ALU_ROR  = 4'h7;
    localparam alu_func_t ALU_AND  = 4'h8;
    localparam alu_func_t ALU_OR   = 4'h9;
    localparam alu_func_t ALU_XOR  = 4'ha;
    localparam alu_func_t ALU_NOR  = 4'hb;
    localparam alu_func_t ALU_NAND = 4'hc;
    localparam alu_func_t ALU_XNOR = 4'hd;
    localparam alu_func_t ALU_GT   = 4'he;
    localparam alu_func_t ALU_EQ   = 4'hf;

    // control fsm states
    typedef enum logic [2:0] {
        IDLE,
        FETCH_ADDR,
        FETCH_READ,
        DECODE,
        EXEC,
        MEM_READ,
        WRITEBACK,
        HALTED
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_func_t func,
    input  wire cpu_pkg::word_t     operand1,
    input  wire cpu_pkg::word_t     operand2,
    output cpu_pkg::word_t          result
);
    import cpu_pkg::*;

    always_comb begin
        case (func)
            // arithmetic, results truncated to the word
            ALU_ADD: result = operand1 + operand2;
            ALU_SUB: result = operand1 - operand2;
            ALU_MUL: result = operand1 * operand2;
            ALU_DIV: begin
                // divide by zero saturates to all ones
                if (operand2 == '0) begin
                    result = '1;
                end else begin
                    result = operand1 / operand2;
                end
            end
            // single-bit shifts and rotates, operand1 only
            ALU_SHL: result = operand1 << 1;
            ALU_SHR: result = operand1 >> 1;
            ALU_ROL: result = {operand1[DATA_W-2:0], operand1[DATA_W-1]};
            ALU_ROR: result = {operand1[0], operand1[DATA_W-1:1]};
            // bitwise logic
            ALU_AND:  result = operand1 & operand2;
            ALU_OR:   result = operand1 | operand2;
            ALU_XOR:  result = operand1 ^ operand2;
            ALU_NOR:  result = ~(operand1 | operand2);
            ALU_NAND: result = ~(operand1 & operand2);
            ALU_XNOR: result = ~(operand1 ^ operand2);
            // compares give 1 or 0, unsigned
            ALU_GT: result = (operand1 > operand2) ? word_t'(1) : word_t'(0);
            ALU_EQ: result = (operand1 == operand2) ? word_t'(1) : word_t'(0);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/main_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module main_memory (
    input  wire                     clk,
    input  wire                     run,
    input  wire cpu_pkg::mem_addr_t cpu_addr,
    input  wire cpu_pkg::word_t     cpu_wdata,
    input  wire                     cpu_we,
    input  wire cpu_pkg::mem_addr_t host_addr,
    input  wire cpu_pkg::word_t     host_wdata,
    input  wire                     host_we,
    output cpu_pkg::word_t          rdata
);
    import cpu_pkg::*;

    word_t     mem [MEM_DEPTH];
    mem_addr_t addr;
    word_t     wdata;
    logic      we;

    // run high gives the cpu the array, run low the host
    always_comb begin
        if (run) begin
            addr  = cpu_addr;
            wdata = cpu_wdata;
            we    = cpu_we;
        end else begin
            addr  = host_addr;
            wdata = host_wdata;
            we    = host_we;
        end
    end

    // write or registered read, rdata holds through a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  wire                     clk,
    input  wire                     rst_n,
    // load strobes from the control unit
    input  wire                     mar_from_pc,
    input  wire                     mar_from_ir,
    input  wire                     ir_load,
    input  wire                     mbr_load,
    input  wire                     pc_inc,
    input  wire                     pc_jump,
    input  wire                     pc_clear,
    input  wire                     acc_from_mbr,
    input  wire                     acc_from_alu,
    // memory side
    input  wire cpu_pkg::word_t     mem_rdata,
    output cpu_pkg::mem_addr_t      mem_addr,
    output cpu_pkg::word_t          acc,
    // status back to control
    output cpu_pkg::opcode_t        opcode,
    output logic                    acc_zero
);
    import cpu_pkg::*;

    mem_addr_t pc;
    mem_addr_t mar;
    mem_addr_t mar_next;
    mem_addr_t ir_addr;
    word_t     mbr;
    word_t     ir;
    word_t     alu_result;
    alu_func_t alu_func;

    // instruction fields
    assign opcode   = opcode_t'(ir[15:12]);
    assign alu_func = alu_func_t'(ir[11:8]);
    assign ir_addr  = mem_addr_t'(ir[7:0]);

    assign acc_zero = (acc == '0);

    // next mar value
    always_comb begin
        if (mar_from_pc) begin
            mar_next = pc;
        end else if (mar_from_ir) begin
            mar_next = ir_addr;
        end else begin
            mar_next = mar;
        end
    end

    // memory sees the address mar is about to take,
    // so the one-cycle read lands in the following state
    assign mem_addr = mar_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else begin
            mar <= mar_next;
        end
    end

    // program counter
    // clear wins over jump, jump over increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_clear) begin
            pc <= '0;
        end else if (pc_jump) begin
            pc <= ir_addr;
        end else if (pc_inc) begin
            // wraps at the top of the 256-word space
            pc <= pc + 1'b1;
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= mem_rdata;
        end
    end

    // memory buffer, operand word for load and alu
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mbr <= '0;
        end else if (mbr_load) begin
            mbr <= mem_rdata;
        end
    end

    // accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_from_mbr) begin
            acc <= mbr;
        end else if (acc_from_alu) begin
            acc <= alu_result;
        end
    end

    // acc is operand1, the fetched word operand2
    alu u_alu (
        .func     (alu_func),
        .operand1 (acc),
        .operand2 (mbr),
        .result   (alu_result)
    );

endmodule

`default_nettype wire

/* hw/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   run,
    input  wire cpu_pkg::opcode_t opcode,
    input  wire                   acc_zero,
    // datapath strobes
    output logic                  mar_from_pc,
    output logic                  mar_from_ir,
    output logic                  ir_load,
    output logic                  mbr_load,
    output logic                  pc_inc,
    output logic                  pc_jump,
    output logic                  pc_clear,
    output logic                  acc_from_mbr,
    output logic                  acc_from_alu,
    // memory write strobe
    output logic                  mem_we,
    output logic                  halted
);
    import cpu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // level output, drops once run falls and fsm is back in idle
    assign halted = (state == HALTED);

    always_comb begin
        // strobes default low
        mar_from_pc  = 1'b0;
        mar_from_ir  = 1'b0;
        ir_load      = 1'b0;
        mbr_load     = 1'b0;
        pc_inc       = 1'b0;
        pc_jump      = 1'b0;
        pc_clear     = 1'b0;
        acc_from_mbr = 1'b0;
        acc_from_alu = 1'b0;
        mem_we       = 1'b0;
        state_next   = state;

        if (!run) begin
            // run low aborts from any state
            state_next = IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // start of a run, program begins at 0
                    pc_clear   = 1'b1;
                    state_next = FETCH_ADDR;
                end
                FETCH_ADDR: begin
                    mar_from_pc = 1'b1;
                    state_next  = FETCH_READ;
                end
                FETCH_READ: begin
                    // memory read in flight
                    state_next = DECODE;
                end
                DECODE: begin
                    ir_load    = 1'b1;
                    pc_inc     = 1'b1;
                    state_next = EXEC;
                end
                EXEC: begin
                    case (opcode)
                        OP_LOAD, OP_ALU: begin
                            mar_from_ir = 1'b1;
                            state_next  = MEM_READ;
                        end
                        OP_STORE: begin
                            mar_from_ir = 1'b1;
                            state_next  = WRITEBACK;
                        end
                        OP_JUMP: begin
                            pc_jump    = 1'b1;
                            state_next = FETCH_ADDR;
                        end
                        OP_JZ: begin
                            // taken only on a zero accumulator
                            pc_jump    = acc_zero;
                            state_next = FETCH_ADDR;
                        end
                        OP_HALT: state_next = HALTED;
                        // unknown opcodes stop the machine too
                        default: state_next = HALTED;
                    endcase
                end
                MEM_READ: begin
                    mbr_load   = 1'b1;
                    state_next = WRITEBACK;
                end
                WRITEBACK: begin
                    acc_from_mbr = (opcode == OP_LOAD);
                    acc_from_alu = (opcode == OP_ALU);
                    mem_we       = (opcode == OP_STORE);
                    state_next   = FETCH_ADDR;
                end
                HALTED: begin
                    // parked until run goes low
                    state_next = HALTED;
                end
                default: state_next = IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/computer.sv */
`timescale 1ns/10ps
`default_nettype none

module computer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     run,
    // host port, used while run is low
    input  wire                     host_we,
    input  wire cpu_pkg::mem_addr_t host_addr,
    input  wire cpu_pkg::word_t     host_wdata,
    output cpu_pkg::word_t          mem_rdata,
    // status
    output cpu_pkg::word_t          acc,
    output logic                    halted
);
    import cpu_pkg::*;

    // control to datapath
    logic mar_from_pc;
    logic mar_from_ir;
    logic ir_load;
    logic mbr_load;
    logic pc_inc;
    logic pc_jump;
    logic pc_clear;
    logic acc_from_mbr;
    logic acc_from_alu;
    logic mem_we;

    // datapath to control and memory
    opcode_t   opcode;
    logic      acc_zero;
    mem_addr_t cpu_addr;

    control_unit u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .opcode       (opcode),
        .acc_zero     (acc_zero),
        .mar_from_pc  (mar_from_pc),
        .mar_from_ir  (mar_from_ir),
        .ir_load      (ir_load),
        .mbr_load     (mbr_load),
        .pc_inc       (pc_inc),
        .pc_jump      (pc_jump),
        .pc_clear     (pc_clear),
        .acc_from_mbr (acc_from_mbr),
        .acc_from_alu (acc_from_alu),
        .mem_we       (mem_we),
        .halted       (halted)
    );

    datapath u_dp (
        .clk          (clk),
        .rst_n        (rst_n),
        .mar_from_pc  (mar_from_pc),
        .mar_from_ir  (mar_from_ir),
        .ir_load      (ir_load),
        .mbr_load     (mbr_load),
        .pc_inc       (pc_inc),
        .pc_jump      (pc_jump),
        .pc_clear     (pc_clear),
        .acc_from_mbr (acc_from_mbr),
        .acc_from_alu (acc_from_alu),
        .mem_rdata    (mem_rdata),
        .mem_addr     (cpu_addr),
        .acc          (acc),
        .opcode       (opcode),
        .acc_zero     (acc_zero)
    );

    // store data is always the accumulator
    main_memory u_mem (
        .clk        (clk),
        .run        (run),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (acc),
        .cpu_we     (mem_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .rdata      (mem_rdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    // free-running clock, 20 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset low for eight rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_computer.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_computer;
    import cpu_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RUN_BOUND     = 50;
    localparam int LOOP_BOUND    = 1000;
    localparam int HOLD_CYCLES   = 12;
    localparam int RANDOM_WORDS  = 16;
    localparam int ALU_CASES     = 18;
    localparam int PROGRAM_SLACK = 20;
    // reset, host test, one load/store run, alu runs, two restart runs, loop
    localparam int WATCHDOG_CYCLES = 20 + RANDOM_WORDS * 2 + HOLD_CYCLES
        + (RUN_BOUND + PROGRAM_SLACK) * (1 + ALU_CASES + 2)
        + (LOOP_BOUND + PROGRAM_SLACK);
    localparam logic [15:0] LFSR_SEED = 16'd53846;
    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_TAPS = 16'hb400;

    logic      clk;
    logic      rst_n;
    logic      run;
    logic      host_we;
    mem_addr_t host_addr;
    word_t     host_wdata;
    word_t     mem_rdata;
    word_t     acc;
    logic      halted;

    logic [15:0] lfsr_state;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    computer u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .mem_rdata  (mem_rdata),
        .acc        (acc),
        .halted     (halted)
    );

    // galois lfsr stepped once per bit handed out
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic word_t random_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[DATA_W-2:0], next_random_bit()};
        end
        return value;
    endfunction

    // opcode | function | address
    function automatic word_t instr(input opcode_t op, input alu_func_t func,
                                    input mem_addr_t addr);
        return {op, func, addr};
    endfunction

    // expected alu result with acc as a and the memory word as b
    function automatic word_t alu_model(input alu_func_t func, input word_t a, input word_t b);
        case (func)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_MUL:  return a * b;
            ALU_DIV:  return (b == 16'h0000) ? 16'hffff : a / b;
            ALU_SHL:  return {a[14:0], 1'b0};
            ALU_SHR:  return {1'b0, a[15:1]};
            ALU_ROL:  return (a << 1) | (a >> 15);
            ALU_ROR:  return (a >> 1) | (a << 15);
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~a & ~b;
            ALU_NAND: return ~a | ~b;
            ALU_XNOR: return (a & b) | (~a & ~b);
            ALU_GT:   return {15'b0, a > b};
            ALU_EQ:   return {15'b0, a == b};
            default:  return '0;
        endcase
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input word_t expected, input word_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // host port tasks enter and leave on a falling edge
    task automatic host_write(input mem_addr_t addr, input word_t data);
        host_addr  = addr;
        host_wdata = data;
        host_we    = 1'b1;
        @(negedge clk);
        host_we    = 1'b0;
    endtask

    task automatic host_read(input mem_addr_t addr, output word_t data);
        host_addr = addr;
        host_we   = 1'b0;
        @(negedge clk);
        data = mem_rdata;
    endtask

    // raise run and wait a bounded time for halted while run stays high
    task automatic run_until_halted(input string test_name, input int bound);
        int  cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        run    = 1'b1;
        while (!done && cycles < bound) begin
            @(negedge clk);
            cycles++;
            done = halted;
        end
        check_count++;
        assert (done) else begin
            $display("%s: machine did not halt within %0d cycles", test_name, bound);
            error_count++;
        end
    endtask

    // hand the memory back to the host
    task automatic stop_machine();
        run = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string test_name, input int start_errors);
        int new_errors;
        new_errors = error_count - start_errors;
        test_count++;
        if (new_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, new_errors);
        end
    endtask

    task automatic reset_and_host_test();
        word_t     written [MEM_DEPTH];
        mem_addr_t addr_list [$];
        mem_addr_t addr;
        word_t     data;
        int        start_errors;
        start_errors = error_count;
        check_value("reset_and_host_port", "halted after reset", '0, word_t'(halted));
        check_value("reset_and_host_port", "acc after reset", '0, acc);
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            addr = mem_addr_t'(random_bits(ADDR_W));
            data = random_bits(DATA_W);
            // repeated address keeps the last word
            written[addr] = data;
            addr_list.push_back(addr);
            host_write(addr, data);
        end
        foreach (addr_list[i]) begin
            host_read(addr_list[i], data);
            check_value("reset_and_host_port", $sformatf("word at %h", addr_list[i]),
                        written[addr_list[i]], data);
        end
        report_test("reset_and_host_port", start_errors);
    endtask

    task automatic load_store_test();
        word_t value;
        word_t stored;
        int    start_errors;
        start_errors = error_count;
        value = random_bits(DATA_W);
        host_write(8'h80, value);
        host_write(8'h81, ~value);
        host_write(8'h00, instr(OP_LOAD, 4'h0, 8'h80));
        host_write(8'h01, instr(OP_STORE, 4'h0, 8'h81));
        host_write(8'h02, instr(OP_HALT, 4'h0, 8'h00));
        run_until_halted("load_store", RUN_BOUND);
        check_value("load_store", "acc", value, acc);
        stop_machine();
        host_read(8'h81, stored);
        check_value("load_store", "copied word", value, stored);
        report_test("load_store", start_errors);
    endtask

    // LOAD x, ALU f y, STORE z, HALT
    task automatic alu_case(input alu_func_t func, input word_t x, input word_t y);
        string test_name;
        word_t expected;
        word_t stored;
        test_name = $sformatf("alu_functions f=%0d", func);
        expected  = alu_model(func, x, y);
        host_write(8'h90, x);
        host_write(8'h91, y);
        // result slot preset to something the store must overwrite
        host_write(8'h92, ~expected);
        host_write(8'h00, instr(OP_LOAD, 4'h0, 8'h90));
        host_write(8'h01, instr(OP_ALU, func, 8'h91));
        host_write(8'h02, instr(OP_STORE, 4'h0, 8'h92));
        host_write(8'h03, instr(OP_HALT, 4'h0, 8'h00));
        run_until_halted(test_name, RUN_BOUND);
        check_value(test_name, "acc", expected, acc);
        stop_machine();
        host_read(8'h92, stored);
        check_value(test_name, "stored result", expected, stored);
    endtask

    task automatic alu_test();
        word_t x;
        word_t y;
        int    start_errors;
        start_errors = error_count;
        for (int f = 0; f < 16; f++) begin
            x = random_bits(DATA_W);
            y = random_bits(DATA_W);
            alu_case(alu_func_t'(f), x, y);
        end
        // corner cases random operands rarely hit
        alu_case(ALU_DIV, random_bits(DATA_W), 16'h0000);
        x = random_bits(DATA_W);
        alu_case(ALU_EQ, x, x);
        report_test("alu_functions", start_errors);
    endtask

    // countdown in a0 with constant one in a1 and pass counter in a2
    task automatic countdown_test();
        word_t count;
        word_t data;
        int    start_errors;
        start_errors = error_count;
        count = random_bits(4) + word_t'(1);
        host_write(8'ha0, count);
        host_write(8'ha1, 16'h0001);
        host_write(8'ha2, 16'h0000);
        host_write(8'h00, instr(OP_LOAD, 4'h0, 8'ha0));
        host_write(8'h01, instr(OP_JZ, 4'h0, 8'h08));
        host_write(8'h02, instr(OP_ALU, ALU_SUB, 8'ha1));
        host_write(8'h03, instr(OP_STORE, 4'h0, 8'ha0));
        host_write(8'h04, instr(OP_LOAD, 4'h0, 8'ha2));
        host_write(8'h05, instr(OP_ALU, ALU_ADD, 8'ha1));
        host_write(8'h06, instr(OP_STORE, 4'h0, 8'ha2));
        host_write(8'h07, instr(OP_JUMP, 4'h0, 8'h00));
        host_write(8'h08, instr(OP_HALT, 4'h0, 8'h00));
        run_until_halted("countdown_loop", LOOP_BOUND);
        check_value("countdown_loop", "acc", 16'h0000, acc);
        stop_machine();
        host_read(8'ha0, data);
        check_value("countdown_loop", "final count", 16'h0000, data);
        host_read(8'ha2, data);
        check_value("countdown_loop", "pass counter", count, data);
        report_test("countdown_loop", start_errors);
    endtask

    task automatic restart_test();
        word_t x;
        word_t y;
        word_t expected;
        word_t stored;
        int    dropped;
        int    start_errors;
        start_errors = error_count;
        x = random_bits(DATA_W);
        y = random_bits(DATA_W);
        expected = alu_model(ALU_ADD, x, y);
        host_write(8'hb0, x);
        host_write(8'hb1, y);
        host_write(8'hb2, ~expected);
        host_write(8'h00, instr(OP_LOAD, 4'h0, 8'hb0));
        host_write(8'h01, instr(OP_ALU, ALU_ADD, 8'hb1));
        host_write(8'h02, instr(OP_STORE, 4'h0, 8'hb2));
        host_write(8'h03, instr(OP_HALT, 4'h0, 8'h00));
        // a restart that skips address 0 stops here without the store
        host_write(8'h04, instr(OP_HALT, 4'h0, 8'h00));
        run_until_halted("halt_and_restart", RUN_BOUND);
        dropped = 0;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (!halted) begin
                dropped++;
            end
        end
        check_count++;
        assert (dropped == 0) else begin
            $display("halt_and_restart: halted fell %0d times while run was held", dropped);
            error_count++;
        end
        check_value("halt_and_restart", "acc first run", expected, acc);
        stop_machine();
        check_count++;
        assert (!halted) else begin
            $display("halt_and_restart: halted still high after run went low");
            error_count++;
        end
        host_read(8'hb2, stored);
        check_value("halt_and_restart", "result first run", expected, stored);
        // wipe the result so the second run has to write it again
        host_write(8'hb2, ~expected);
        run_until_halted("halt_and_restart", RUN_BOUND);
        check_value("halt_and_restart", "acc second run", expected, acc);
        stop_machine();
        host_read(8'hb2, stored);
        check_value("halt_and_restart", "result second run", expected, stored);
        report_test("halt_and_restart", start_errors);
    endtask

    // backstop for a machine that never halts
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        run        = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = LFSR_SEED;
        @(posedge rst_n);
        @(negedge clk);
        reset_and_host_test();
        load_store_test();
        alu_test();
        countdown_test();
        restart_test();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_pkg.sv
hw/alu.sv
hw/main_memory.sv
hw/datapath.sv
hw/control_unit.sv
hw/computer.sv
testbench/tb_clock.sv
testbench/tb_computer.sv
